// File: logic/bus_pkg.sv
package bus_pkg;

    // Bus widths
    localparam int BUS_ADDR_W = 16;
    localparam int BUS_DATA_W = 32;

    // One CPU access, carried together with the start strobe
    typedef struct packed {
        logic [BUS_ADDR_W-1:0] addr;
        logic [BUS_DATA_W-1:0] wdata;
        logic                  we;
    } bus_req_t;

    // Memory unit sequence
    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESPOND
    } bus_state_e;

    // Decoded target of an access
    typedef enum logic [2:0] {
        REGION_VRAM32,
        REGION_VRAM8,
        REGION_GPO,
        REGION_GPI,
        REGION_FRAMES,
        REGION_NONE
    } bus_region_e;

    // Memory map
    localparam logic [BUS_ADDR_W-1:0] VRAM32_BASE = 16'h0000;
    localparam int                    VRAM32_WORDS = 512;

    localparam logic [BUS_ADDR_W-1:0] VRAM8_BASE = 16'h0200;
    localparam int                    VRAM8_WORDS = 128;

    // I/O registers
    localparam logic [BUS_ADDR_W-1:0] GPO_ADDR    = 16'h0300;
    localparam logic [BUS_ADDR_W-1:0] GPI_ADDR    = 16'h0301;
    localparam logic [BUS_ADDR_W-1:0] FRAMES_ADDR = 16'h0302;

    localparam int GPIO_BITS = 4;

    // Width of the frame_drawn counter
    localparam int FRAMES_W = 16;

endpackage

// File: logic/video_pkg.sv
package video_pkg;

    // Horizontal timing in clocks
    localparam int H_ACTIVE     = 64;
    localparam int H_TOTAL      = 80;
    localparam int H_SYNC_START = 68;
    localparam int H_SYNC_END   = 74;

    // Vertical timing in lines
    localparam int V_ACTIVE     = 48;
    localparam int V_TOTAL      = 56;
    localparam int V_SYNC_START = 50;
    localparam int V_SYNC_END   = 52;

    localparam int H_CNT_W = $clog2(H_TOTAL);
    localparam int V_CNT_W = $clog2(V_TOTAL);

    // Tile geometry
    localparam int TILE_SIZE = 8;
    localparam int TILE_BITS = $clog2(TILE_SIZE);
    localparam int TILES_X   = 8;
    localparam int TILES_Y   = 6;

    // Colour map sits above the tile map in VRAM8
    localparam int COLOR_OFFSET = 64;

    // Counter to pixel output delay
    localparam int RENDER_LATENCY = 3;

    // VRAM geometry
    localparam int VRAM32_DW = 32;
    localparam int VRAM8_DW  = 8;
    localparam int VRAM32_AW = $clog2(bus_pkg::VRAM32_WORDS);
    localparam int VRAM8_AW  = $clog2(bus_pkg::VRAM8_WORDS);

    // RGB332 pixel with syncs (active low) and blank
    typedef struct packed {
        logic [2:0] r;
        logic [2:0] g;
        logic [1:0] b;
        logic       hs;
        logic       vs;
        logic       blank;
    } pixel_out_t;

endpackage

// File: logic/vram.sv
`timescale 1ns/1ps

module vram #(
    parameter int WIDTH = 8,
    parameter int WORDS = 128
) (
    input  logic                     clk,

    // CPU port
    input  logic [$clog2(WORDS)-1:0] cpu_addr,
    input  logic [WIDTH-1:0]         cpu_d,
    input  logic                     cpu_we,
    output logic [WIDTH-1:0]         cpu_q,

    // Renderer port, read only
    input  logic [$clog2(WORDS)-1:0] gpu_addr,
    output logic [WIDTH-1:0]         gpu_q
);

    logic [WIDTH-1:0] mem [WORDS];

    // CPU side, read returns the old word on a write
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_d;
        end
        cpu_q <= mem[cpu_addr];
    end

    // Renderer side sees old data on a same-cycle write
    always_ff @(posedge clk) begin
        gpu_q <= mem[gpu_addr];
    end

endmodule

// File: logic/memory_unit.sv
`timescale 1ns/1ps

module memory_unit
    import bus_pkg::*;
    import video_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    // CPU bus
    input  bus_req_t              req,
    input  logic                  start,
    output logic                  busy,
    output logic [BUS_DATA_W-1:0] q,

    // VRAM32 CPU port
    output logic [VRAM32_AW-1:0]  vram32_addr,
    output logic [VRAM32_DW-1:0]  vram32_d,
    output logic                  vram32_we,
    input  logic [VRAM32_DW-1:0]  vram32_q,

    // VRAM8 CPU port
    output logic [VRAM8_AW-1:0]   vram8_addr,
    output logic [VRAM8_DW-1:0]   vram8_d,
    output logic                  vram8_we,
    input  logic [VRAM8_DW-1:0]   vram8_q,

    // I/O
    input  logic [GPIO_BITS-1:0]  gpi,
    output logic [GPIO_BITS-1:0]  gpo,
    input  logic                  frame_drawn
);

    bus_state_e            state;
    bus_req_t              req_r;
    bus_region_e           region;
    logic [FRAMES_W-1:0]   frames;
    logic [BUS_DATA_W-1:0] rdata;

    function automatic bus_region_e decode(input logic [BUS_ADDR_W-1:0] addr);
        logic [BUS_ADDR_W-1:0] off32;
        logic [BUS_ADDR_W-1:0] off8;
        off32 = addr - VRAM32_BASE;
        off8  = addr - VRAM8_BASE;
        // Offsets wrap below the base, so one compare covers the range
        if (off32 < BUS_ADDR_W'(VRAM32_WORDS)) begin
            return REGION_VRAM32;
        end else if (off8 < BUS_ADDR_W'(VRAM8_WORDS)) begin
            return REGION_VRAM8;
        end else if (addr == GPO_ADDR) begin
            return REGION_GPO;
        end else if (addr == GPI_ADDR) begin
            return REGION_GPI;
        end else if (addr == FRAMES_ADDR) begin
            return REGION_FRAMES;
        end
        return REGION_NONE;
    endfunction

    assign busy = (state != IDLE);

    // VRAM ports follow the latched request, write only in ACCESS
    assign vram32_addr = VRAM32_AW'(req_r.addr - VRAM32_BASE);
    assign vram32_d    = req_r.wdata;
    assign vram32_we   = (state == ACCESS) && (region == REGION_VRAM32) && req_r.we;

    assign vram8_addr  = VRAM8_AW'(req_r.addr - VRAM8_BASE);
    assign vram8_d     = req_r.wdata[VRAM8_DW-1:0];
    assign vram8_we    = (state == ACCESS) && (region == REGION_VRAM8) && req_r.we;

    // Read mux, VRAM data is valid in RESPOND
    always_comb begin
        case (region)
            REGION_VRAM32: rdata = vram32_q;
            REGION_VRAM8:  rdata = BUS_DATA_W'(vram8_q);
            REGION_GPO:    rdata = BUS_DATA_W'(gpo);
            REGION_GPI:    rdata = BUS_DATA_W'(gpi);
            REGION_FRAMES: rdata = BUS_DATA_W'(frames);
            default:       rdata = '0;
        endcase
    end

    // Request capture, starts while busy are dropped
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            req_r  <= req;
            region <= decode(req.addr);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= IDLE;
            gpo    <= '0;
            frames <= '0;
            q      <= '0;
        end else begin
            if (frame_drawn) begin
                frames <= frames + 1'b1;
            end

            case (state)
                IDLE: begin
                    if (start) begin
                        state <= ACCESS;
                    end
                end
                ACCESS: begin
                    state <= RESPOND;
                    if (region == REGION_GPO && req_r.we) begin
                        gpo <= req_r.wdata[GPIO_BITS-1:0];
                    end
                end
                RESPOND: begin
                    state <= IDLE;
                    q     <= rdata;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: logic/fsx_renderer.sv
`timescale 1ns/1ps

module fsx_renderer
    import video_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    // VRAM8 renderer port, tile map and colour map
    output logic [VRAM8_AW-1:0]  vram8_addr,
    input  logic [VRAM8_DW-1:0]  vram8_q,

    // VRAM32 renderer port, patterns
    output logic [VRAM32_AW-1:0] vram32_addr,
    input  logic [VRAM32_DW-1:0] vram32_q,

    output pixel_out_t           pix,
    output logic                 frame_drawn
);

    logic [H_CNT_W-1:0] h_cnt;
    logic [V_CNT_W-1:0] v_cnt;

    // Stage 1 decode of the counters
    logic                active;
    logic                hs_now;
    logic                vs_now;
    logic                tile_start;
    logic [VRAM8_AW-1:0] map_addr;

    // Sync and blank delay line
    logic [RENDER_LATENCY-1:0] hs_pipe;
    logic [RENDER_LATENCY-1:0] vs_pipe;
    logic [RENDER_LATENCY-1:0] blank_pipe;

    // Fetch pipeline position
    logic [VRAM8_AW-1:0]  s1_map_addr;
    logic [TILE_BITS-1:0] s1_col;
    logic [TILE_BITS-1:0] s1_row;
    logic [TILE_BITS-1:0] s2_col;
    logic [TILE_BITS-1:0] s2_row;

    logic [VRAM8_DW-1:0] tile_sel;
    logic [VRAM8_DW-1:0] tile_hold;
    logic [VRAM8_DW-1:0] colour_sel;
    logic [VRAM8_DW-1:0] colour_hold;
    logic                pat_bit;
    logic [VRAM8_DW-1:0] col_q;

    assign active = (h_cnt < H_CNT_W'(H_ACTIVE)) && (v_cnt < V_CNT_W'(V_ACTIVE));
    assign hs_now = !((h_cnt >= H_CNT_W'(H_SYNC_START)) && (h_cnt < H_CNT_W'(H_SYNC_END)));
    assign vs_now = !((v_cnt >= V_CNT_W'(V_SYNC_START)) && (v_cnt < V_CNT_W'(V_SYNC_END)));

    assign tile_start = (h_cnt[TILE_BITS-1:0] == '0);
    assign map_addr   = VRAM8_AW'((v_cnt / TILE_SIZE) * TILES_X + h_cnt / TILE_SIZE);

    // The map is read once per tile, the colour read uses the free slot after it
    assign vram8_addr = tile_start ? map_addr : VRAM8_AW'(COLOR_OFFSET + s1_map_addr);

    // Stage 2 pattern fetch, tile index arrives only on the first column
    assign tile_sel    = (s1_col == '0) ? vram8_q : tile_hold;
    assign vram32_addr = VRAM32_AW'({tile_sel, s1_row[TILE_BITS-1]});

    // Stage 3, colour arrives on the first column and is held for the tile
    assign colour_sel = (s2_col == '0) ? vram8_q : colour_hold;
    assign pat_bit    = vram32_q[{s2_row[1:0], s2_col}];

    always_ff @(posedge clk) begin
        s1_map_addr <= map_addr;
        s1_col      <= h_cnt[TILE_BITS-1:0];
        s1_row      <= v_cnt[TILE_BITS-1:0];
        s2_col      <= s1_col;
        s2_row      <= s1_row;
        tile_hold   <= tile_sel;
        colour_hold <= colour_sel;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            h_cnt       <= '0;
            v_cnt       <= '0;
            hs_pipe     <= '1;
            vs_pipe     <= '1;
            blank_pipe  <= '1;
            col_q       <= '0;
            frame_drawn <= 1'b0;
        end else begin
            if (h_cnt == H_CNT_W'(H_TOTAL - 1)) begin
                h_cnt <= '0;
                if (v_cnt == V_CNT_W'(V_TOTAL - 1)) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end

            hs_pipe    <= {hs_pipe[RENDER_LATENCY-2:0], hs_now};
            vs_pipe    <= {vs_pipe[RENDER_LATENCY-2:0], vs_now};
            blank_pipe <= {blank_pipe[RENDER_LATENCY-2:0], !active};

            // Black outside the active area and on clear pattern bits
            if (blank_pipe[RENDER_LATENCY-2] || !pat_bit) begin
                col_q <= '0;
            end else begin
                col_q <= colour_sel;
            end

            // High while the counter sits at column 0 of line V_ACTIVE
            frame_drawn <= (h_cnt == H_CNT_W'(H_TOTAL - 1)) &&
                           (v_cnt == V_CNT_W'(V_ACTIVE - 1));
        end
    end

    assign pix = '{
        r:     col_q[7:5],
        g:     col_q[4:2],
        b:     col_q[1:0],
        hs:    hs_pipe[RENDER_LATENCY-1],
        vs:    vs_pipe[RENDER_LATENCY-1],
        blank: blank_pipe[RENDER_LATENCY-1]
    };

endmodule

// File: logic/fpgc_video_top.sv
`timescale 1ns/1ps

module fpgc_video_top
    import bus_pkg::*;
    import video_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    // CPU bus
    input  bus_req_t              req,
    input  logic                  start,
    output logic                  busy,
    output logic [BUS_DATA_W-1:0] q,

    input  logic [GPIO_BITS-1:0]  gpi,
    output logic [GPIO_BITS-1:0]  gpo,

    // Video out and frame interrupt
    output pixel_out_t            pix,
    output logic                  frame_drawn
);

    logic [VRAM32_AW-1:0] vram32_cpu_addr;
    logic [VRAM32_DW-1:0] vram32_cpu_d;
    logic                 vram32_cpu_we;
    logic [VRAM32_DW-1:0] vram32_cpu_q;
    logic [VRAM32_AW-1:0] vram32_gpu_addr;
    logic [VRAM32_DW-1:0] vram32_gpu_q;

    logic [VRAM8_AW-1:0]  vram8_cpu_addr;
    logic [VRAM8_DW-1:0]  vram8_cpu_d;
    logic                 vram8_cpu_we;
    logic [VRAM8_DW-1:0]  vram8_cpu_q;
    logic [VRAM8_AW-1:0]  vram8_gpu_addr;
    logic [VRAM8_DW-1:0]  vram8_gpu_q;

    memory_unit mu (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .start       (start),
        .busy        (busy),
        .q           (q),
        .vram32_addr (vram32_cpu_addr),
        .vram32_d    (vram32_cpu_d),
        .vram32_we   (vram32_cpu_we),
        .vram32_q    (vram32_cpu_q),
        .vram8_addr  (vram8_cpu_addr),
        .vram8_d     (vram8_cpu_d),
        .vram8_we    (vram8_cpu_we),
        .vram8_q     (vram8_cpu_q),
        .gpi         (gpi),
        .gpo         (gpo),
        .frame_drawn (frame_drawn)
    );

    // Pattern memory
    vram #(
        .WIDTH (VRAM32_DW),
        .WORDS (VRAM32_WORDS)
    ) vram32 (
        .clk      (clk),
        .cpu_addr (vram32_cpu_addr),
        .cpu_d    (vram32_cpu_d),
        .cpu_we   (vram32_cpu_we),
        .cpu_q    (vram32_cpu_q),
        .gpu_addr (vram32_gpu_addr),
        .gpu_q    (vram32_gpu_q)
    );

    // Tile map and colour map
    vram #(
        .WIDTH (VRAM8_DW),
        .WORDS (VRAM8_WORDS)
    ) vram8 (
        .clk      (clk),
        .cpu_addr (vram8_cpu_addr),
        .cpu_d    (vram8_cpu_d),
        .cpu_we   (vram8_cpu_we),
        .cpu_q    (vram8_cpu_q),
        .gpu_addr (vram8_gpu_addr),
        .gpu_q    (vram8_gpu_q)
    );

    fsx_renderer fsx (
        .clk         (clk),
        .rst         (rst),
        .vram8_addr  (vram8_gpu_addr),
        .vram8_q     (vram8_gpu_q),
        .vram32_addr (vram32_gpu_addr),
        .vram32_q    (vram32_gpu_q),
        .pix         (pix),
        .frame_drawn (frame_drawn)
    );

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

// File: tests/fpgc_video_checker.sv
`timescale 1ns/1ps

module fpgc_video_checker
    import video_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       busy,
    input logic       frame_drawn,
    input pixel_out_t pix
);

    // An access holds busy for exactly two cycles
    busy_len_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(busy) |-> $past(busy, 2) && !$past(busy, 3))
        else $error("busy fell after a run shorter than two cycles");

    busy_len_max: assert property (@(posedge clk) disable iff (rst)
        busy && $past(busy) |-> !$past(busy, 2))
        else $error("busy stayed high for more than two cycles");

    frame_pulse: assert property (@(posedge clk) disable iff (rst)
        frame_drawn |=> !frame_drawn)
        else $error("frame_drawn high for two cycles in a row");

    // No colour outside the active area
    blank_black: assert property (@(posedge clk) disable iff (rst)
        pix.blank |-> ({pix.r, pix.g, pix.b} == 8'h00))
        else $error("colour not zero while blank is high");

    reset_idle: assert property (@(posedge clk)
        $fell(rst) |-> !busy && !frame_drawn)
        else $error("busy or frame_drawn high right after reset");

endmodule

bind fpgc_video_top fpgc_video_checker protocol_checker (
    .clk         (clk),
    .rst         (rst),
    .busy        (busy),
    .frame_drawn (frame_drawn),
    .pix         (pix)
);

// File: tests/fpgc_video_tb.sv
`timescale 1ns/1ps

module fpgc_video_tb
    import bus_pkg::*;
    import video_pkg::*;
();

    localparam int FRAME_CYCLES    = H_TOTAL * V_TOTAL;
    localparam int WATCHDOG_CYCLES = 8 * FRAME_CYCLES + 4000;
    localparam int BUS_CYCLES      = 3;

    logic                  clk;
    logic                  rst;
    bus_req_t              req;
    logic                  start;
    logic                  busy;
    logic [BUS_DATA_W-1:0] q;
    logic [GPIO_BITS-1:0]  gpi;
    logic [GPIO_BITS-1:0]  gpo;
    pixel_out_t            pix;
    logic                  frame_drawn;

    int errors;
    int timeouts;

    // Expected VRAM contents
    logic [VRAM32_DW-1:0] pat_mem [VRAM32_WORDS];
    logic [VRAM8_DW-1:0]  map_mem [VRAM8_WORDS];

    tb_clock_gen #(.PERIOD_NS(20)) clock_gen (.clk(clk));

    fpgc_video_top DUT (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .start       (start),
        .busy        (busy),
        .q           (q),
        .gpi         (gpi),
        .gpo         (gpo),
        .pix         (pix),
        .frame_drawn (frame_drawn)
    );

    // Inputs change 2 ns after the edge, outputs are read there too
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("error: %s expected 0x%0h actual 0x%0h", test, expected, actual);
        end
    endtask

    task automatic bus_access(input logic [BUS_ADDR_W-1:0] addr,
                              input logic [BUS_DATA_W-1:0] wdata, input logic we,
                              output logic [BUS_DATA_W-1:0] rdata);
        int cycles;
        req.addr  = addr;
        req.wdata = wdata;
        req.we    = we;
        start     = 1'b1;
        step();
        start  = 1'b0;
        cycles = 1;
        while (busy && cycles < 16) begin
            step();
            cycles++;
        end
        if (busy) begin
            timeouts++;
            $display("Bus access to 0x%04h never finished", addr);
        end
        check_value($sformatf("latency 0x%04h", addr), 32'(BUS_CYCLES), 32'(cycles));
        rdata = q;
    endtask

    task automatic bus_write(input logic [BUS_ADDR_W-1:0] addr,
                             input logic [BUS_DATA_W-1:0] wdata);
        logic [BUS_DATA_W-1:0] unused;
        bus_access(addr, wdata, 1'b1, unused);
    endtask

    task automatic bus_read(input logic [BUS_ADDR_W-1:0] addr,
                            output logic [BUS_DATA_W-1:0] rdata);
        bus_access(addr, '0, 1'b0, rdata);
    endtask

    // Returns in the cycle that shows the pulse
    task automatic wait_frame();
        int n;
        n = 0;
        do begin
            step();
            n++;
        end while (!frame_drawn && n <= FRAME_CYCLES);
        if (!frame_drawn) begin
            timeouts++;
            $display("No frame_drawn pulse within one frame period");
        end
    endtask

    // Tile map, colour map and 1-bit patterns
    function automatic logic [7:0] pixel_colour(input int x, input int y);
        logic [VRAM8_AW-1:0]  n;
        logic [VRAM32_AW-1:0] w;
        logic [4:0]           b;
        logic [31:0]          word;
        if (x < 0 || x >= H_ACTIVE || y < 0 || y >= V_ACTIVE) begin
            return 8'h00;
        end
        n    = VRAM8_AW'((y / TILE_SIZE) * TILES_X + x / TILE_SIZE);
        w    = VRAM32_AW'(2 * int'(map_mem[n]) + (y % TILE_SIZE) / 4);
        b    = 5'((y % 4) * 8 + x % TILE_SIZE);
        word = pat_mem[w];
        return word[b] ? map_mem[VRAM8_AW'(COLOR_OFFSET) + n] : 8'h00;
    endfunction

    task automatic test_reset();
        logic [BUS_DATA_W-1:0] rdata;
        check_value("reset busy", 32'd0, 32'(busy));
        check_value("reset frame_drawn", 32'd0, 32'(frame_drawn));
        check_value("reset gpo", 32'd0, 32'(gpo));
        check_value("reset blank", 32'd1, 32'(pix.blank));
        check_value("reset hs", 32'd1, 32'(pix.hs));
        check_value("reset vs", 32'd1, 32'(pix.vs));
        bus_read(FRAMES_ADDR, rdata);
        check_value("reset frames", 32'd0, rdata);
    endtask

    task automatic test_vram();
        logic [VRAM32_AW-1:0]  a32 [16];
        logic [VRAM8_AW-1:0]   a8 [16];
        logic [BUS_DATA_W-1:0] data;
        for (int i = 0; i < 16; i++) begin
            a32[i] = VRAM32_AW'($urandom_range(VRAM32_WORDS - 1));
            data   = $urandom();
            bus_write(VRAM32_BASE + 16'(a32[i]), data);
            pat_mem[a32[i]] = data;
            a8[i] = VRAM8_AW'($urandom_range(VRAM8_WORDS - 1));
            data  = $urandom();
            bus_write(VRAM8_BASE + 16'(a8[i]), data);
            map_mem[a8[i]] = data[7:0];
        end
        for (int i = 0; i < 16; i++) begin
            bus_read(VRAM32_BASE + 16'(a32[i]), data);
            check_value($sformatf("vram32 read %0d", a32[i]), pat_mem[a32[i]], data);
            bus_read(VRAM8_BASE + 16'(a8[i]), data);
            check_value($sformatf("vram8 read %0d", a8[i]), 32'(map_mem[a8[i]]), data);
        end
    endtask

    task automatic test_registers();
        logic [BUS_DATA_W-1:0] data;
        logic [BUS_DATA_W-1:0] rdata;
        for (int i = 0; i < 4; i++) begin
            data = $urandom();
            bus_write(GPO_ADDR, data);
            check_value("gpo pins", 32'(data[GPIO_BITS-1:0]), 32'(gpo));
            bus_read(GPO_ADDR, rdata);
            check_value("gpo read", 32'(data[GPIO_BITS-1:0]), rdata);
            gpi = GPIO_BITS'($urandom());
            bus_read(GPI_ADDR, rdata);
            check_value("gpi read", 32'(gpi), rdata);
        end
        bus_write(16'h0400, $urandom());
        bus_read(16'h0400, rdata);
        check_value("unmapped 0x0400", 32'd0, rdata);
        bus_write(16'hffff, $urandom());
        bus_read(16'hffff, rdata);
        check_value("unmapped 0xffff", 32'd0, rdata);
    endtask

    task automatic test_render();
        logic [VRAM8_AW-1:0] idx;
        logic                prev_blank;
        int                  x;
        int                  y;
        int                  n;
        int                  pixels;
        for (int t = 0; t < TILES_X * TILES_Y; t++) begin
            idx          = VRAM8_AW'(t);
            map_mem[idx] = 8'($urandom());
            bus_write(VRAM8_BASE + 16'(idx), 32'(map_mem[idx]));
            idx          = VRAM8_AW'(COLOR_OFFSET + t);
            map_mem[idx] = 8'($urandom());
            bus_write(VRAM8_BASE + 16'(idx), 32'(map_mem[idx]));
        end
        for (int w = 0; w < VRAM32_WORDS; w++) begin
            pat_mem[VRAM32_AW'(w)] = $urandom();
            bus_write(VRAM32_BASE + 16'(w), pat_mem[VRAM32_AW'(w)]);
        end
        wait_frame();
        // Whole active frame lies between two pulses
        x          = 0;
        y          = -1;
        n          = 0;
        pixels     = 0;
        prev_blank = 1'b1;
        do begin
            step();
            n++;
            if (prev_blank && !pix.blank) begin
                y++;
                x = 0;
            end
            if (!pix.blank) begin
                check_value($sformatf("render pixel (%0d,%0d)", x, y),
                            32'(pixel_colour(x, y)), 32'({pix.r, pix.g, pix.b}));
                x++;
                pixels++;
            end
            prev_blank = pix.blank;
        end while (!frame_drawn && n <= FRAME_CYCLES);
        check_value("render pixel count", 32'(H_ACTIVE * V_ACTIVE), 32'(pixels));
    endtask

    task automatic test_syncs();
        logic prev_hs;
        logic prev_vs;
        logic prev_blank;
        logic in_line;
        int   last_hs;
        int   last_vs;
        int   vs_falls;
        int   hs_per_frame;
        int   run;
        prev_hs      = pix.hs;
        prev_vs      = pix.vs;
        prev_blank   = pix.blank;
        in_line      = 1'b0;
        last_hs      = -1;
        last_vs      = -1;
        vs_falls     = 0;
        hs_per_frame = 0;
        run          = 0;
        for (int cyc = 0; vs_falls < 2 && cyc < 2 * FRAME_CYCLES + H_TOTAL; cyc++) begin
            step();
            if (prev_hs && !pix.hs) begin
                if (last_hs >= 0) begin
                    check_value("hsync period", 32'(H_TOTAL), 32'(cyc - last_hs));
                end
                last_hs = cyc;
                // Lines between the two vsync falls
                if (vs_falls == 1) begin
                    hs_per_frame++;
                end
            end
            if (prev_vs && !pix.vs) begin
                if (last_vs >= 0) begin
                    check_value("vsync period", 32'(FRAME_CYCLES), 32'(cyc - last_vs));
                end
                last_vs = cyc;
                vs_falls++;
            end
            if (prev_blank && !pix.blank) begin
                in_line = 1'b1;
                run     = 0;
            end
            if (!pix.blank) begin
                run++;
            end else if (!prev_blank && in_line) begin
                check_value("active pixels per line", 32'(H_ACTIVE), 32'(run));
            end
            prev_hs    = pix.hs;
            prev_vs    = pix.vs;
            prev_blank = pix.blank;
        end
        if (vs_falls < 2) begin
            timeouts++;
            $display("Fewer than two vsync pulses seen in two frame periods");
        end
        check_value("hsync pulses per frame", 32'(V_TOTAL), 32'(hs_per_frame));
    endtask

    task automatic test_frames();
        logic [BUS_DATA_W-1:0] f0;
        logic [BUS_DATA_W-1:0] f1;
        // Read right after a pulse so none lands inside the access
        wait_frame();
        bus_read(FRAMES_ADDR, f0);
        repeat (3) wait_frame();
        bus_read(FRAMES_ADDR, f1);
        check_value("frame counter delta", 32'd3, 32'(16'(f1 - f0)));
    endtask

    initial begin
        void'($urandom(32'h94ee8ff8));
        errors   = 0;
        timeouts = 0;
        rst      = 1'b1;
        start    = 1'b0;
        req      = '0;
        gpi      = '0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        test_reset();
        test_vram();
        test_registers();
        test_render();
        test_syncs();
        test_frames();

        $display("Summary: %0d check errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Roughly 7 frames of waiting plus the bus traffic fit inside this
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the tests finished",
                 WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: sources.f
logic/bus_pkg.sv
logic/video_pkg.sv
logic/vram.sv
logic/memory_unit.sv
logic/fsx_renderer.sv
logic/fpgc_video_top.sv
tests/tb_clock_gen.sv
tests/fpgc_video_checker.sv
tests/fpgc_video_tb.sv

// File: Makefile
# Verilator flow for the video path testbench

VERILATOR ?= verilator
TOP       ?= fpgc_video_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Regression passed" $(LOG) || \
		{ echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
